//--- verilog/corePkg.sv
// integer core package
// word and register index widths, ALU and branch encodings,
// and the payloads carried by the two stage registers
package corePkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,
        aluSll = 4'd6,
        aluSrl = 4'd7,
        aluLui = 4'd8
    } aluOpE;

    typedef enum logic [1:0] {
        brNone = 2'd0,
        brEq   = 2'd1,
        brNe   = 2'd2
    } branchE;

    // decoded instruction held between ID and EXE
    typedef struct packed {
        logic                    valid;
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    busA;       // rs read data
        logic [dataWidth-1:0]    busB;       // rt read data
        logic [dataWidth-1:0]    imm32;      // already extended
        logic [4:0]              shamt;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] dst;
        logic                    regWrite;
        aluOpE                   aluOp;
        logic                    aluSrcB;    // imm32 as operand B
        branchE                  branchKind;
    } idExPayloadT;

    // result held between EXE and WB
    typedef struct packed {
        logic                    valid;
        logic                    regWrite;
        logic [regAddrWidth-1:0] dst;
        logic [dataWidth-1:0]    result;
    } exWbPayloadT;

endpackage

//--- verilog/regFile.sv
// register file
// 32 general registers, two combinational read ports and one write port;
// a read of the register being written sees the new value, r0 reads zero
module regFile (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [corePkg::regAddrWidth-1:0] raddrA,
    input  logic [corePkg::regAddrWidth-1:0] raddrB,
    output logic [corePkg::dataWidth-1:0]    rdataA,
    output logic [corePkg::dataWidth-1:0]    rdataB,
    input  logic                             we,
    input  logic [corePkg::regAddrWidth-1:0] waddr,
    input  logic [corePkg::dataWidth-1:0]    wdata
);
    import corePkg::*;

    logic [dataWidth-1:0] regs [0:2**regAddrWidth-1];
    logic                 wrEn;

    assign wrEn = we && rstN && (waddr != '0); // r0 is never stored

    always_ff @(posedge clk) begin
        if (wrEn) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so WB and ID can share a cycle
    assign rdataA = (raddrA == '0)                 ? '0    :
                    (wrEn && (waddr == raddrA))    ? wdata :
                                                     regs[raddrA];

    assign rdataB = (raddrB == '0)                 ? '0    :
                    (wrEn && (waddr == raddrB))    ? wdata :
                                                     regs[raddrB];

endmodule

//--- verilog/instrDecoder.sv
// instruction decoder
// splits the instruction word into register indices and immediate,
// and picks the ALU op, operand B source, destination and branch kind;
// anything not recognised becomes a no-op that neither writes nor branches
module instrDecoder (
    input  logic [corePkg::dataWidth-1:0]    instr,
    output logic [corePkg::regAddrWidth-1:0] rs,
    output logic [corePkg::regAddrWidth-1:0] rt,
    output logic [corePkg::regAddrWidth-1:0] dst,
    output logic [corePkg::dataWidth-1:0]    imm32,
    output logic [4:0]                       shamt,
    output logic                             regWrite,
    output corePkg::aluOpE                   aluOp,
    output logic                             aluSrcB,
    output corePkg::branchE                  branchKind
);
    import corePkg::*;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;

    localparam logic [5:0] fnSll     = 6'h00;
    localparam logic [5:0] fnSrl     = 6'h02;
    localparam logic [5:0] fnAddu    = 6'h21;
    localparam logic [5:0] fnSubu    = 6'h23;
    localparam logic [5:0] fnAnd     = 6'h24;
    localparam logic [5:0] fnOr      = 6'h25;
    localparam logic [5:0] fnXor     = 6'h26;
    localparam logic [5:0] fnSlt     = 6'h2a;

    logic [5:0]              opcode;
    logic [5:0]              funct;
    logic [regAddrWidth-1:0] rd;
    logic [15:0]             imm16;
    logic                    writes;     // before the r0 check
    logic                    useRd;      // R-type destination
    logic                    signExt;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    always_comb begin
        writes     = 1'b0;
        useRd      = 1'b0;
        signExt    = 1'b0;
        aluOp      = aluAdd;
        aluSrcB    = 1'b0;
        branchKind = brNone;
        case (opcode)
            opSpecial: begin
                useRd  = 1'b1;
                writes = 1'b1;
                case (funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    default: writes = 1'b0; // unknown funct
                endcase
            end
            opAddiu: begin
                writes  = 1'b1;
                signExt = 1'b1;
                aluSrcB = 1'b1;
            end
            opOri: begin
                writes  = 1'b1;
                aluSrcB = 1'b1;
                aluOp   = aluOr;
            end
            opLui: begin
                writes  = 1'b1;
                aluSrcB = 1'b1;
                aluOp   = aluLui;
            end
            opBeq: begin
                signExt    = 1'b1;
                branchKind = brEq;
            end
            opBne: begin
                signExt    = 1'b1;
                branchKind = brNe;
            end
            default: begin
                writes = 1'b0; // no-op
            end
        endcase
    end

    assign dst      = useRd ? rd : rt;
    assign regWrite = writes && (dst != '0); // writes to r0 are dropped here
    assign imm32    = signExt ? {{(dataWidth-16){imm16[15]}}, imm16}
                              : {{(dataWidth-16){1'b0}}, imm16};

endmodule

//--- verilog/pipeReg.sv
// pipeline stage register
// holds one stage payload of any packed type; reset clears it, and a
// flush loads an all-zero bubble in place of d on an advancing edge
module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    flush,
    input  logic    wr,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            q <= '0;                 // valid field goes low
        end else if (wr) begin
            if (flush) begin
                q <= '0;             // squashed slot
            end else begin
                q <= d;
            end
        end
    end

    // while wr is low the stage holds, a pending flush waits with it

endmodule

//--- verilog/execUnit.sv
// execute stage
// picks forwarded or registered operands, runs the ALU and resolves
// branches with their target address
module execUnit (
    input  corePkg::idExPayloadT          idEx,
    input  logic                          fwdA,
    input  logic                          fwdB,
    input  logic [corePkg::dataWidth-1:0] fwdData,
    output logic [corePkg::dataWidth-1:0] result,
    output logic                          branchTaken,
    output logic [corePkg::dataWidth-1:0] branchTarget
);
    import corePkg::*;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluB;
    logic                 sltBit;
    logic                 operandsEqual;

    assign opA  = fwdA ? fwdData : idEx.busA;   // WB bypass
    assign opB  = fwdB ? fwdData : idEx.busB;
    assign aluB = idEx.aluSrcB ? idEx.imm32 : opB;

    assign sltBit = $signed(opA) < $signed(aluB);

    always_comb begin
        case (idEx.aluOp)
            aluAdd:  result = opA + aluB;
            aluSub:  result = opA - aluB;
            aluAnd:  result = opA & aluB;
            aluOr:   result = opA | aluB;
            aluXor:  result = opA ^ aluB;
            aluSlt:  result = {{(dataWidth-1){1'b0}}, sltBit};
            aluSll:  result = aluB << idEx.shamt;  // shifts act on rt
            aluSrl:  result = aluB >> idEx.shamt;
            aluLui:  result = {aluB[15:0], {(dataWidth-16){1'b0}}};
            default: result = '0;
        endcase
    end

    // branches compare rs with rt, never the immediate
    assign operandsEqual = (opA == opB);

    always_comb begin
        case (idEx.branchKind)
            brEq:    branchTaken = idEx.valid && operandsEqual;
            brNe:    branchTaken = idEx.valid && !operandsEqual;
            default: branchTaken = 1'b0;
        endcase
    end

    // no delay slot, target is relative to pc + 4
    assign branchTarget = idEx.pc + dataWidth'(4)
                        + {idEx.imm32[dataWidth-3:0], 2'b00};

endmodule

//--- verilog/hazardUnit.sv
// hazard logic
// WB-to-EXE forwarding selects and the squash of the ID/EXE register
// when the branch in EXE is taken
module hazardUnit (
    input  logic [corePkg::regAddrWidth-1:0] exRs,
    input  logic [corePkg::regAddrWidth-1:0] exRt,
    input  logic [corePkg::regAddrWidth-1:0] wbDst,
    input  logic                             wbRegWrite,
    input  logic                             wbValid,
    input  logic                             branchTaken,
    output logic                             fwdA,
    output logic                             fwdB,
    output logic                             idExFlush
);

    logic wbWrites;

    // r0 is never a forwarding source
    assign wbWrites = wbValid && wbRegWrite && (wbDst != '0);

    assign fwdA = wbWrites && (wbDst == exRs);
    assign fwdB = wbWrites && (wbDst == exRt);

    // one younger instr sits in ID behind a taken branch
    assign idExFlush = branchTaken;

endmodule

//--- verilog/intCore.sv
// integer core top
// ID decode and register read, ID/EXE register, execute, EXE/WB register,
// with WB forwarding and branch squash; hold freezes every stage
module intCore (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [corePkg::dataWidth-1:0]    instr,
    input  logic [corePkg::dataWidth-1:0]    pc,
    input  logic                             instrValid,
    input  logic                             hold,
    output logic                             wbValid,
    output logic [corePkg::regAddrWidth-1:0] wbDst,
    output logic [corePkg::dataWidth-1:0]    wbData,
    output logic                             redirect,
    output logic [corePkg::dataWidth-1:0]    redirectPc
);
    import corePkg::*;

    logic [regAddrWidth-1:0] idRs;
    logic [regAddrWidth-1:0] idRt;
    logic [regAddrWidth-1:0] idDst;
    logic [dataWidth-1:0]    idImm32;
    logic [dataWidth-1:0]    idBusA;
    logic [dataWidth-1:0]    idBusB;
    logic [4:0]              idShamt;
    logic                    idRegWrite;
    logic                    idAluSrcB;
    aluOpE                   idAluOp;
    branchE                  idBranchKind;
    idExPayloadT             idExD;
    idExPayloadT             idExQ;
    exWbPayloadT             exWbD;
    exWbPayloadT             exWbQ;
    logic [dataWidth-1:0]    exResult;
    logic                    fwdA;
    logic                    fwdB;
    logic                    idExFlush;
    logic                    advance;

    assign advance = !hold;

    instrDecoder decoder_i (.instr(instr), .rs(idRs), .rt(idRt), .dst(idDst),
        .imm32(idImm32), .shamt(idShamt), .regWrite(idRegWrite), .aluOp(idAluOp),
        .aluSrcB(idAluSrcB), .branchKind(idBranchKind));

    regFile regFile_i (.clk(clk), .rstN(rstN), .raddrA(idRs), .raddrB(idRt),
        .rdataA(idBusA), .rdataB(idBusB), .we(wbValid && advance),
        .waddr(wbDst), .wdata(wbData));

    assign idExD = '{valid: instrValid, pc: pc, busA: idBusA, busB: idBusB,
                     imm32: idImm32, shamt: idShamt, rs: idRs, rt: idRt,
                     dst: idDst, regWrite: idRegWrite, aluOp: idAluOp,
                     aluSrcB: idAluSrcB, branchKind: idBranchKind};

    pipeReg #(.payloadT(idExPayloadT)) idExReg (.clk(clk), .rstN(rstN),
        .flush(idExFlush), .wr(advance), .d(idExD), .q(idExQ));

    execUnit exec_i (.idEx(idExQ), .fwdA(fwdA), .fwdB(fwdB), .fwdData(wbData),
        .result(exResult), .branchTaken(redirect), .branchTarget(redirectPc));

    hazardUnit hazard_i (.exRs(idExQ.rs), .exRt(idExQ.rt), .wbDst(exWbQ.dst),
        .wbRegWrite(exWbQ.regWrite), .wbValid(exWbQ.valid), .branchTaken(redirect),
        .fwdA(fwdA), .fwdB(fwdB), .idExFlush(idExFlush));

    assign exWbD = '{valid: idExQ.valid, regWrite: idExQ.regWrite,
                     dst: idExQ.dst, result: exResult};

    pipeReg #(.payloadT(exWbPayloadT)) exWbReg (.clk(clk), .rstN(rstN),
        .flush(1'b0), .wr(advance), .d(exWbD), .q(exWbQ));

    assign wbValid = exWbQ.valid && exWbQ.regWrite; // branches and no-ops drop out
    assign wbDst   = exWbQ.dst;
    assign wbData  = exWbQ.result;

endmodule

//--- verif/core_checker.sv
// assertion checker for the integer core
// reset values, output stability under hold and no writeback into r0
module coreChecker (
    input logic                             clk,
    input logic                             rstN,
    input logic                             hold,
    input logic                             wbValid,
    input logic [corePkg::regAddrWidth-1:0] wbDst,
    input logic [corePkg::dataWidth-1:0]    wbData,
    input logic                             redirect,
    input logic [corePkg::dataWidth-1:0]    redirectPc
);
    timeunit 1ns;
    timeprecision 100ps;

    int assertFails = 0;    // summed into the testbench error counts

    resetQuiet: assert property (@(posedge clk) !rstN |=> (!wbValid && !redirect))
        else begin
            assertFails++;
            $error("wbValid or redirect high after a reset edge");
        end

    // a held edge must leave every output where it was
    holdFreeze: assert property (@(posedge clk) disable iff (!rstN)
        hold |=> ($stable(wbValid) && $stable(wbDst) && $stable(wbData)
                  && $stable(redirect) && $stable(redirectPc)))
        else begin
            assertFails++;
            $error("outputs changed across a held edge");
        end

    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
        wbValid |-> ((wbDst != '0) || (wbData == '0)))
        else begin
            assertFails++;
            $error("writeback to r0 with nonzero data");
        end

endmodule

bind intCore coreChecker checker_i (.clk(clk), .rstN(rstN), .hold(hold),
    .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData), .redirect(redirect),
    .redirectPc(redirectPc));

//--- verif/coreTb.sv
// testbench for the integer core
// feeds instruction streams, keeps a program-order register model and
// checks writebacks and branch redirects as they leave the core
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;
    import corePkg::*;

    localparam int halfPeriod     = 20;
    localparam int resetCycles    = 4;
    localparam int numTests       = 5;
    localparam int slotsPerTest   = 32;   // instructions plus drain slots
    localparam int maxHold        = 7;
    localparam int watchdogCycles = resetCycles + numTests * slotsPerTest * (maxHold + 1) + 40;

    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] fnSll   = 6'h00;
    localparam logic [5:0] fnSrl   = 6'h02;
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnXor   = 6'h26;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnMult  = 6'h18;

    logic                    clk = 1'b0;
    logic                    rstN, instrValid, hold, wbValid, redirect;
    logic [dataWidth-1:0]    instr, pc, wbData, redirectPc;
    logic [regAddrWidth-1:0] wbDst;

    logic [dataWidth-1:0]    model [0:31];    // reference register file
    logic [regAddrWidth-1:0] expDstQ [$];
    logic [dataWidth-1:0]    expDataQ [$];
    logic [dataWidth-1:0]    expTargetQ [$];
    int                      expWbEdgeQ [$];
    int                      expRedirEdgeQ [$];
    int                      advEdges = 0;    // advancing edges since reset
    logic                    squashNext;
    logic [dataWidth-1:0]    squashTarget, curPc;
    logic [15:0]             lfsr = 16'd26;
    int                      valueErrors = 0;
    int                      seqErrors = 0;

    intCore dut_i (.clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .instrValid(instrValid),
        .hold(hold), .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData),
        .redirect(redirect), .redirectPc(redirectPc));

    always #halfPeriod clk = ~clk;

    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic randBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);    // one step per bit
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] rOp(logic [5:0] fn, int rd, int rs, int rt, int sh);
        return {opRtype, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] iOp(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    task automatic checkWb(input logic [regAddrWidth-1:0] gotDst, expDst,
                           input logic [dataWidth-1:0] gotData, expData);
        if (gotDst !== expDst || gotData !== expData) begin
            valueErrors++;
            $display("Fail at %0t ns: writeback r%0d = %h, expected r%0d = %h",
                     $time, gotDst, gotData, expDst, expData);
        end
    endtask

    task automatic checkRedirect(input logic [dataWidth-1:0] got, exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Fail at %0t ns: redirect to %h, expected %h", $time, got, exp);
        end
    endtask

    // a result must leave exactly its pipeline latency after acceptance
    task automatic confirmLatency(input string what, input int expEdge);
        if (advEdges != expEdge) begin
            seqErrors++;
            $display("%s came out on advancing edge %0d instead of %0d at %0t ns",
                     what, advEdges, expEdge, $time);
        end
    endtask

    // applies MIPS semantics in program order as each instruction is presented
    task automatic modelInstr(input logic [dataWidth-1:0] w);
        logic [dataWidth-1:0] a, b, sImm, res;
        logic [4:0]           dst;
        logic                 writes;
        a      = model[w[25:21]];
        b      = model[w[20:16]];
        sImm   = {{16{w[15]}}, w[15:0]};
        dst    = w[20:16];
        writes = 1'b1;
        res    = '0;
        case (w[31:26])
            opRtype: begin
                dst = w[15:11];
                case (w[5:0])
                    fnAddu:  res = a + b;
                    fnSubu:  res = a - b;
                    fnAnd:   res = a & b;
                    fnOr:    res = a | b;
                    fnXor:   res = a ^ b;
                    fnSlt:   res = {31'b0, $signed(a) < $signed(b)};
                    fnSll:   res = b << w[10:6];
                    fnSrl:   res = b >> w[10:6];
                    default: writes = 1'b0;
                endcase
            end
            opAddiu: res = a + sImm;
            opOri:   res = a | {16'h0, w[15:0]};
            opLui:   res = {w[15:0], 16'h0};
            opBeq, opBne: begin
                writes = 1'b0;
                if ((a == b) == (w[31:26] == opBeq)) begin
                    squashNext   = 1'b1;
                    squashTarget = curPc + 4 + (sImm << 2);
                    expTargetQ.push_back(squashTarget);
                    expRedirEdgeQ.push_back(advEdges + 2);  // in EXE one edge after accept
                end
            end
            default: writes = 1'b0;
        endcase
        if (writes && dst != 0) begin
            model[dst] = res;
            expDstQ.push_back(dst);
            expDataQ.push_back(res);
            expWbEdgeQ.push_back(advEdges + 3);    // counted two edges after accept
        end
    endtask

    // presents one issue slot and holds it for holdCycles edges
    task automatic stepSlot(input logic valid, input logic [dataWidth-1:0] w,
                            input int holdCycles);
        @(negedge clk);
        instr      = w;
        pc         = curPc;
        instrValid = valid;
        hold       = (holdCycles > 0);
        if (squashNext) begin
            squashNext = 1'b0;      // flushed behind the taken branch
            curPc      = squashTarget;
        end else begin
            if (valid) begin
                modelInstr(w);
            end
            curPc = curPc + 4;
        end
        repeat (holdCycles) @(negedge clk);
        hold = 1'b0;
    endtask

    task automatic issue(input logic [dataWidth-1:0] w);
        stepSlot(1'b1, w, 0);
    endtask

    task automatic loadRandom(input int r);
        logic [31:0] v;
        randBits(32, v);
        issue(iOp(opLui, 0, r, v[31:16]));
        issue(iOp(opOri, r, r, v[15:0]));    // forwarded from the LUI
    endtask

    // idle until every expected result is out, then watch a few more edges
    task automatic drain();
        int waited;
        waited = 0;
        while ((expDstQ.size() != 0 || expTargetQ.size() != 0) && waited < 10) begin
            stepSlot(1'b0, '0, 0);
            waited++;
        end
        repeat (3) stepSlot(1'b0, '0, 0);
        if (expDstQ.size() != 0 || expTargetQ.size() != 0) begin
            seqErrors++;
            $display("%0d writebacks and %0d redirects never arrived by %0t ns",
                     expDstQ.size(), expTargetQ.size(), $time);
            expDstQ.delete();
            expDataQ.delete();
            expTargetQ.delete();
            expWbEdgeQ.delete();
            expRedirEdgeQ.delete();
        end
    endtask

    always @(posedge clk) begin
        if (rstN && !hold) begin
            advEdges++;
            if (wbValid) begin
                if (expDstQ.size() == 0) begin
                    seqErrors++;
                    $display("unexpected writeback to r%0d at %0t ns", wbDst, $time);
                end else begin
                    confirmLatency("writeback", expWbEdgeQ.pop_front());
                    checkWb(wbDst, expDstQ.pop_front(), wbData, expDataQ.pop_front());
                end
            end
            if (redirect) begin
                if (expTargetQ.size() == 0) begin
                    seqErrors++;
                    $display("unexpected redirect to %h at %0t ns", redirectPc, $time);
                end else begin
                    confirmLatency("redirect", expRedirEdgeQ.pop_front());
                    checkRedirect(redirectPc, expTargetQ.pop_front());
                end
            end
        end
    end

    task automatic aluOpsSweep();
        logic [31:0] sh;
        loadRandom(1);
        loadRandom(2);
        randBits(5, sh);
        issue(rOp(fnAddu, 3, 1, 2, 0));
        issue(rOp(fnSubu, 4, 1, 2, 0));
        issue(rOp(fnAnd, 5, 1, 2, 0));
        issue(rOp(fnOr, 6, 1, 2, 0));
        issue(rOp(fnXor, 7, 1, 2, 0));
        issue(rOp(fnSlt, 8, 1, 2, 0));
        issue(rOp(fnSlt, 9, 2, 1, 0));
        issue(rOp(fnSll, 10, 0, 1, sh));
        issue(rOp(fnSrl, 11, 0, 2, sh));
        issue(iOp(opAddiu, 1, 12, 16'hfffd));
        issue(iOp(opOri, 2, 13, 16'h8001));
        issue(iOp(opLui, 0, 14, 16'h8001));
        drain();
    endtask

    task automatic forwardingPaths();
        issue(iOp(opAddiu, 0, 1, 16'd5));
        issue(rOp(fnAddu, 2, 1, 1, 0));        // both operands from WB
        issue(iOp(opAddiu, 0, 4, 16'hfff9));
        issue(iOp(opAddiu, 0, 5, 16'd1));
        issue(rOp(fnSubu, 6, 4, 2, 0));        // r4 comes through the write-through path
        issue(rOp(fnXor, 7, 6, 5, 0));
        issue(rOp(fnSlt, 8, 7, 5, 0));
        drain();
    endtask

    task automatic branchRedirects();
        loadRandom(1);
        loadRandom(2);
        issue(iOp(opBeq, 1, 1, 16'd3));
        issue(iOp(opAddiu, 0, 20, 16'h0011));  // squashed
        issue(iOp(opAddiu, 0, 21, 16'h0022));
        issue(iOp(opBne, 1, 2, 16'hfffe));     // backward target
        issue(iOp(opAddiu, 0, 22, 16'h0033));
        issue(iOp(opBeq, 1, 2, 16'd5));
        issue(iOp(opAddiu, 0, 23, 16'h0044));
        issue(iOp(opBne, 2, 2, 16'd1));        // never taken
        issue(iOp(opAddiu, 0, 24, 16'h0055));
        issue(iOp(opAddiu, 0, 25, 16'h0009));
        issue(iOp(opBne, 25, 24, 16'd2));      // compare on bypassed operands
        issue(iOp(opAddiu, 0, 26, 16'h0066));
        drain();
    endtask

    task automatic holdStalls();
        logic [31:0] pick, rs, rt, rd, imm, hc;
        for (int i = 0; i < 14; i++) begin
            randBits(2, pick);
            randBits(3, rs);
            randBits(3, rt);
            randBits(3, rd);
            randBits(16, imm);
            randBits(3, hc);
            case (pick[1:0])
                2'd0:    stepSlot(1'b1, rOp(fnAddu, rd, rs, rt, 0), hc);
                2'd1:    stepSlot(1'b1, rOp(fnSubu, rd, rs, rt, 0), hc);
                2'd2:    stepSlot(1'b1, rOp(fnXor, rd, rs, rt, 0), hc);
                default: stepSlot(1'b1, iOp(opAddiu, rs, rd, imm[15:0]), hc);
            endcase
        end
        drain();
    endtask

    task automatic zeroRegAndIllegal();
        issue(iOp(opAddiu, 0, 0, 16'h0055));
        issue(rOp(fnAddu, 0, 1, 2, 0));
        issue(rOp(fnOr, 9, 0, 0, 0));          // r0 still reads zero
        issue(iOp(opLw, 1, 2, 16'h0010));
        issue(rOp(fnMult, 3, 1, 2, 0));
        issue(iOp(opAddi, 1, 4, 16'h0001));
        issue(rOp(fnOr, 10, 0, 1, 0));
        drain();
    endtask

    initial begin
        rstN       = 1'b0;
        instr      = '0;
        pc         = '0;
        instrValid = 1'b0;
        hold       = 1'b0;
        squashNext = 1'b0;
        curPc      = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        aluOpsSweep();
        forwardingPaths();
        branchRedirects();
        holdStalls();
        zeroRegAndIllegal();
        $display("errors: %0d value, %0d sequence, %0d assertion",
                 valueErrors, seqErrors, dut_i.checker_i.assertFails);
        if (valueErrors + seqErrors + dut_i.checker_i.assertFails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * 2 * halfPeriod);
        $display("watchdog expired after %0d cycles, the stream did not finish",
                 watchdogCycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- files.f
verilog/corePkg.sv
verilog/regFile.sv
verilog/instrDecoder.sv
verilog/pipeReg.sv
verilog/execUnit.sv
verilog/hazardUnit.sv
verilog/intCore.sv
verif/core_checker.sv
verif/coreTb.sv

//--- Makefile
# Verilator build and run for the integer core testbench

OBJ_DIR := obj_dir
LOG     := run.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module coreTb \
		-f files.f --Mdir $(OBJ_DIR) -o coreSim

run: compile
	-./$(OBJ_DIR)/coreSim +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
